// ==== hdl/mcu_pkg.sv ====
// Memory map, opcodes, vectors and bus type shared by the MCU subsystem

package mcu_pkg;

    // Controller memory map
    // ROM where the top two address bits are 11
    localparam logic [15:0] rom_base    = 16'hC000;
    // Shared RAM where the top nibble is 8
    localparam logic [15:0] shared_base = 16'h8000;
    // Internal RAM, upper bound is exclusive
    localparam logic [15:0] iram_lo     = 16'h0040;
    localparam logic [15:0] iram_hi     = 16'h0140;
    // On-chip ports live below this address
    localparam logic [15:0] port_top    = 16'h0028;
    localparam logic [5:0]  port6_addr  = 6'h17;

    // Sequencer start and interrupt addresses
    localparam logic [15:0] reset_pc    = 16'hC000;
    localparam logic [15:0] nmi_vector  = 16'hFF00;

    // Instruction set
    // Two bytes: opcode, immediate
    localparam logic [7:0]  op_ldi      = 8'h86;
    // Three bytes: opcode, address low, address high
    localparam logic [7:0]  op_lda      = 8'hB6;
    localparam logic [7:0]  op_sta      = 8'hB7;
    localparam logic [7:0]  op_jmp      = 8'h7E;
    // One byte, any unknown opcode behaves the same
    localparam logic [7:0]  op_nop      = 8'h01;

    // Controller bus
    // Each access has an address phase with vma high,
    // followed by a data phase with vma low
    typedef struct packed {
        logic        vma;
        logic        rnw;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } mcu_bus_t;

endpackage

// ==== hdl/mcu_ports.sv ====
// Port 6 output register and the NMI latch of the controller
`timescale 1ns/1ps

module mcu_ports import mcu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       port_we,
    input  logic [5:0] port_addr,
    input  logic [7:0] wdata,
    input  logic       nmi_set,
    output logic       irq_main,
    output logic       nmi
);

    logic [7:0] port6;
    logic       nmi_set_d;
    logic       nmi_clr;

    // Bit 1 interrupts the main CPU, bit 0 low holds the NMI cleared
    assign irq_main = port6[1];
    assign nmi_clr  = ~port6[0];

    // Only port 6 is implemented
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port6 <= 8'h00;
        end else if (port_we && port_addr == port6_addr) begin
            port6 <= wdata;
        end
    end

    // Set on a rising edge of nmi_set, clear wins
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nmi_set_d <= 1'b0;
            nmi       <= 1'b0;
        end else begin
            nmi_set_d <= nmi_set;
            if (nmi_clr) begin
                nmi <= 1'b0;
            end else if (nmi_set && !nmi_set_d) begin
                nmi <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        nmi_clr |=> !nmi)
    else $error("NMI latch set while port 6 holds it clear");

endmodule

// ==== hdl/mcu_seq.sv ====
// Accumulator sequencer that fetches and runs instructions over the controller bus
`timescale 1ns/1ps

module mcu_seq import mcu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       halt,
    input  logic       nmi,
    input  logic [7:0] rdata,
    output mcu_bus_t   bus
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_op_lo,
        st_op_hi,
        st_exec
    } state_t;

    state_t      state;
    logic        dphase;
    logic        nmi_busy;
    logic [15:0] pc;
    logic [7:0]  acc;
    logic [7:0]  opcode;
    logic [7:0]  oper_lo;

    // state tells what the access in flight is for,
    // dphase tells which half of it we are in
    always_ff @(posedge clk or posedge rst) begin : fsm
        logic        boundary;
        logic        fetch;
        logic [15:0] pc_next;
        if (rst) begin
            state    <= st_idle;
            dphase   <= 1'b0;
            nmi_busy <= 1'b0;
            pc       <= reset_pc;
            acc      <= 8'h00;
            opcode   <= op_nop;
            oper_lo  <= 8'h00;
            bus      <= '{vma: 1'b0, rnw: 1'b1, addr: 16'h0000, wdata: 8'h00};
        end else begin
            boundary = 1'b0;
            fetch    = 1'b0;
            pc_next  = pc;
            // Served NMI is rearmed once the latch drops
            if (!nmi) begin
                nmi_busy <= 1'b0;
            end
            if (cen) begin
                if (state == st_idle) begin
                    boundary = 1'b1;
                end else if (!dphase) begin
                    // Address phase over, a write has just landed
                    dphase  <= 1'b1;
                    bus.vma <= 1'b0;
                    bus.rnw <= 1'b1;
                end else begin
                    // Data phase over, rdata is valid
                    dphase <= 1'b0;
                    case (state)
                        st_fetch: begin
                            opcode <= rdata;
                            if (rdata == op_ldi || rdata == op_lda ||
                                rdata == op_sta || rdata == op_jmp) begin
                                state <= st_op_lo;
                                fetch = 1'b1;
                            end else begin
                                boundary = 1'b1;
                            end
                        end
                        st_op_lo: begin
                            if (opcode == op_ldi) begin
                                acc <= rdata;
                                boundary = 1'b1;
                            end else begin
                                // Addresses come low byte first
                                oper_lo <= rdata;
                                state   <= st_op_hi;
                                fetch = 1'b1;
                            end
                        end
                        st_op_hi: begin
                            if (opcode == op_jmp) begin
                                pc_next  = {rdata, oper_lo};
                                boundary = 1'b1;
                            end else begin
                                state <= st_exec;
                                bus   <= '{vma: 1'b1, rnw: opcode != op_sta,
                                           addr: {rdata, oper_lo}, wdata: acc};
                            end
                        end
                        default: begin
                            if (opcode == op_lda) begin
                                acc <= rdata;
                            end
                            boundary = 1'b1;
                        end
                    endcase
                end
                if (boundary) begin
                    if (halt) begin
                        state <= st_idle;
                    end else begin
                        if (nmi && !nmi_busy) begin
                            nmi_busy <= 1'b1;
                            pc_next = nmi_vector;
                        end
                        state <= st_fetch;
                        fetch = 1'b1;
                    end
                end
                if (fetch) begin
                    bus <= '{vma: 1'b1, rnw: 1'b1, addr: pc_next, wdata: acc};
                    pc  <= pc_next + 16'd1;
                end else begin
                    pc <= pc_next;
                end
            end
        end
    end

    // Store data must not move while the ROM stretches the cycle
    assert property (@(posedge clk) disable iff (rst)
        bus.vma && !bus.rnw && !cen |=> $stable(bus.wdata))
    else $error("Store data changed during the address phase");

endmodule

// ==== hdl/mcu_sub.sv ====
// MCU subsystem top with address decoding, shared RAM arbitration and read mux
`timescale 1ns/1ps

module mcu_sub import mcu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen6,
    // Main CPU side
    input  logic [8:0]  cpu_addr,
    input  logic        cpu_wrn,
    input  logic [7:0]  cpu_dout,
    input  logic        com_cs,
    output logic [7:0]  shared_dout,
    output logic        ban,
    input  logic        nmi_set,
    input  logic        halt,
    output logic        irq_main,
    // Program ROM
    output logic [13:0] rom_addr,
    input  logic [7:0]  rom_data,
    output logic        rom_cs,
    input  logic        rom_ok
);

    mcu_bus_t   bus;
    logic [7:0] mcu_din;
    logic       iram_cs;
    logic       shared_cs;
    logic       port_cs;
    logic       iram_rd;
    logic       shared_rd;
    logic       waitn;
    logic       cpu_cen;
    logic [8:0] shared_addr;
    logic [7:0] shared_data;
    logic       shared_we;
    logic       iram_we;
    logic       port_we;
    logic [7:0] iram_dout;
    logic       nmi;

    assign ban      = ~rom_cs;
    assign rom_addr = bus.addr[13:0];
    assign cpu_cen  = cen6 & waitn;

    // Address decoder
    always_comb begin
        rom_cs    = 1'b0;
        iram_cs   = 1'b0;
        shared_cs = 1'b0;
        port_cs   = 1'b0;
        if (bus.vma) begin
            rom_cs    = bus.addr[15:14] == rom_base[15:14];
            iram_cs   = bus.addr >= iram_lo && bus.addr < iram_hi;
            shared_cs = bus.addr[15:12] == shared_base[15:12];
            port_cs   = bus.addr < port_top;
        end
    end

    // Controller owns the shared RAM only while vma is high
    always_comb begin
        if (bus.vma) begin
            shared_addr = bus.addr[8:0];
            shared_data = bus.wdata;
            shared_we   = shared_cs & ~bus.rnw;
        end else begin
            shared_addr = cpu_addr;
            shared_data = cpu_dout;
            shared_we   = com_cs & ~cpu_wrn;
        end
    end

    assign iram_we = iram_cs & ~bus.rnw;
    assign port_we = port_cs & ~bus.rnw & cpu_cen;

    // Selects are gone by the data phase, so remember them
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iram_rd   <= 1'b0;
            shared_rd <= 1'b0;
        end else if (cpu_cen) begin
            iram_rd   <= iram_cs;
            shared_rd <= shared_cs;
        end
    end

    // Read mux, ROM by default
    always_comb begin
        if (iram_rd) begin
            mcu_din = iram_dout;
        end else if (shared_rd) begin
            mcu_din = shared_dout;
        end else begin
            mcu_din = rom_data;
        end
    end

    mcu_seq u_seq (
        .clk   (clk),
        .rst   (rst),
        .cen   (cpu_cen),
        .halt  (halt),
        .nmi   (nmi),
        .rdata (mcu_din),
        .bus   (bus)
    );

    rom_wait u_wait (
        .clk    (clk),
        .rst    (rst),
        .rom_cs (rom_cs),
        .rom_ok (rom_ok),
        .waitn  (waitn)
    );

    mcu_ports u_ports (
        .clk       (clk),
        .rst       (rst),
        .port_we   (port_we),
        .port_addr (bus.addr[5:0]),
        .wdata     (bus.wdata),
        .nmi_set   (nmi_set),
        .irq_main  (irq_main),
        .nmi       (nmi)
    );

    spram #(.aw(9)) u_shared (
        .clk  (clk),
        .cen  (cen6),
        .we   (shared_we),
        .addr (shared_addr),
        .data (shared_data),
        .q    (shared_dout)
    );

    // 0x100-0x13F folds onto 0x00-0x3F, which no other address uses
    spram #(.aw(8)) u_iram (
        .clk  (clk),
        .cen  (cpu_cen),
        .we   (iram_we),
        .addr (bus.addr[7:0]),
        .data (bus.wdata),
        .q    (iram_dout)
    );

endmodule

// ==== hdl/rom_wait.sv ====
// Wait-state generator that holds the controller while the ROM fetches
`timescale 1ns/1ps

module rom_wait (
    input  logic clk,
    input  logic rst,
    input  logic rom_cs,
    input  logic rom_ok,
    output logic waitn
);

    logic last_cs;

    // Negative edge, so waitn is settled before the next cen6 edge
    always_ff @(negedge clk or posedge rst) begin
        if (rst) begin
            waitn   <= 1'b1;
            last_cs <= 1'b0;
        end else begin
            last_cs <= rom_cs;
            if (rom_cs && !last_cs) begin
                waitn <= 1'b0;
            end else if (rom_ok) begin
                waitn <= 1'b1;
            end
        end
    end

    // A stall without a pending ROM access would hang the controller
    assert property (@(negedge clk) disable iff (rst)
        !rom_cs && !waitn |=> waitn)
    else $error("waitn held low with no ROM access");

endmodule

// ==== hdl/spram.sv ====
// Single-port RAM with registered read and clock enable
`timescale 1ns/1ps

module spram #(
    parameter int aw = 8
) (
    input  logic          clk,
    input  logic          cen,
    input  logic          we,
    input  logic [aw-1:0] addr,
    input  logic [7:0]    data,
    output logic [7:0]    q
);

    logic [7:0] mem [0:(2**aw)-1];

    // Read returns the old contents during a write
    always_ff @(posedge clk) begin
        if (cen) begin
            if (we) begin
                mem[addr] <= data;
            end
            q <= mem[addr];
        end
    end

endmodule

// ==== sim/tb_mcu_sub.sv ====
// Testbench for the MCU subsystem with random programs and an instruction-level model
`timescale 1ns/1ps

module tb_mcu_sub import mcu_pkg::*; ();

    logic        clk, rst, cen6, cpu_wrn, com_cs, ban, nmi_set, halt, irq_main;
    logic        rom_cs, rom_ok;
    logic [8:0]  cpu_addr;
    logic [7:0]  cpu_dout, shared_dout, rom_data;
    logic [13:0] rom_addr;

    // Reference model state
    logic [7:0]  prog [0:16383];
    logic [7:0]  sh_m [0:511];
    logic        sh_k [0:511];
    logic [7:0]  ir_m [0:511];
    logic [15:0] ia_list [0:63];
    logic [7:0]  m_acc, m_port6, rd;
    logic [15:0] gp, a16, ma;
    int          checks, errors, err_base, cycles, deadline, n_ia;

    mcu_sub dut (.*);
    tb_rom  rom (.clk(clk), .rom_cs(rom_cs), .rom_addr(rom_addr),
                 .rom_data(rom_data), .rom_ok(rom_ok));

    always #4 clk = ~clk;
    always @(posedge clk) #1 cen6 = ~cen6;

    always @(posedge clk) begin
        cycles++;
        if (cycles > deadline) begin
            $display("Run stopped at cycle %0d, the DUT did not respond in time", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task compare_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %0t %s expected %02h actual %02h", $time, name, exp, got);
            errors++;
        end
    endtask

    task report(input string name);
        $display("%-28s %s", name, (errors == err_base) ? "ok" : "FAILED");
        err_base = errors;
    endtask

    task arm_timeout(input int len);
        deadline = cycles + 40 * len + 2000;
    endtask

    task wait_cen();
        @(posedge clk);
        while (!cen6) @(posedge clk);
    endtask

    task emit(input logic [7:0] b);
        rom.put(gp[13:0], b);
        prog[gp[13:0]] = b;
        gp++;
    endtask

    task emit3(input logic [7:0] op, input logic [15:0] a);
        emit(op);
        emit(a[7:0]);
        emit(a[15:8]);
    endtask

    task model_write(input logic [15:0] a, input logic [7:0] d);
        if (a[15:12] == 4'h8) begin
            sh_m[a[8:0]] = d;
            sh_k[a[8:0]] = 1'b1;
        end else if (a >= 16'h0040 && a < 16'h0140) begin
            ir_m[a[8:0]] = d;
        end else if (a < 16'h0028 && a[5:0] == 6'h17) begin
            m_port6 = d;
        end
    endtask

    // Runs the program from start until the PC reaches stop
    task model_run(input logic [15:0] start, input logic [15:0] stop);
        logic [15:0] pc, a;
        logic [7:0]  op;
        pc = start;
        while (pc != stop) begin
            op = prog[pc[13:0]];
            a  = {prog[14'(pc + 2)], prog[14'(pc + 1)]};
            if (op == op_ldi) begin
                m_acc = prog[14'(pc + 1)];
                pc += 2;
            end else if (op == op_lda) begin
                m_acc = (a[15:12] == 4'h8) ? sh_m[a[8:0]] : ir_m[a[8:0]];
                pc += 3;
            end else if (op == op_sta) begin
                model_write(a, m_acc);
                pc += 3;
            end else if (op == op_jmp) begin
                pc = a;
            end else begin
                pc += 1;
            end
        end
    endtask

    task apply_reset();
        halt = 1'b1;
        rst  = 1'b1;
        m_acc   = 8'h00;
        m_port6 = 8'h00;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task wait_fetch(input logic [15:0] a);
        @(posedge clk);
        while (!(rom_cs && rom_addr == a[13:0])) @(posedge clk);
    endtask

    task wait_idle();
        int cnt;
        cnt = 0;
        while (cnt < 20) begin
            @(posedge clk);
            cnt = ban ? cnt + 1 : 0;
        end
    endtask

    task cpu_write(input logic [8:0] a, input logic [7:0] d);
        @(posedge clk);
        #1 cpu_addr = a;
        cpu_dout = d;
        com_cs   = 1'b1;
        cpu_wrn  = 1'b0;
        wait_cen();
        #1 com_cs = 1'b0;
        cpu_wrn  = 1'b1;
        sh_m[a] = d;
        sh_k[a] = 1'b1;
    endtask

    task cpu_read(input logic [8:0] a, output logic [7:0] d);
        @(posedge clk);
        #1 cpu_addr = a;
        wait_cen();
        #1 d = shared_dout;
    endtask

    task check_shared();
        arm_timeout(64);
        for (int i = 0; i < 512; i++) begin
            if (sh_k[i]) begin
                cpu_read(9'(i), rd);
                compare_byte($sformatf("shared_dout[%03h]", i), sh_m[i], rd);
            end
        end
    endtask

    // Resets, runs until the closing self jump, halts and reads back
    task run_prog(input logic [15:0] stop);
        arm_timeout(gp - reset_pc);
        apply_reset();
        model_run(reset_pc, stop);
        @(posedge clk);
        #1 halt = 1'b0;
        wait_fetch(stop);
        #1 halt = 1'b1;
        wait_idle();
        check_shared();
    endtask

    task fire_nmi();
        #1 nmi_set = 1'b1;
        repeat (3) @(posedge clk);
        #1 nmi_set = 1'b0;
        wait_fetch(nmi_vector + 16'h000F);
        model_run(nmi_vector, nmi_vector + 16'h000F);
        #1 halt = 1'b1;
        wait_idle();
        cpu_read(ma[8:0], rd);
        compare_byte("shared_dout marker", sh_m[ma[8:0]], rd);
        compare_byte("irq_main", {7'b0, m_port6[1]}, {7'b0, irq_main});
    endtask

    initial begin
        clk      = 0;
        rst      = 1;
        cen6     = 0;
        halt     = 1;
        nmi_set  = 0;
        cpu_addr = 0;
        cpu_wrn  = 1;
        cpu_dout = 0;
        com_cs   = 0;
        checks   = 0;
        errors   = 0;
        err_base = 0;
        cycles   = 0;
        deadline = 4000;
        void'($urandom(39640));
        for (int i = 0; i < 512; i++) sh_k[i] = 1'b0;

        // Test 1, quiet outputs through and after reset
        for (int i = 0; i < 30; i++) begin
            @(posedge clk);
            compare_byte("ban", 8'h01, {7'b0, ban});
            compare_byte("irq_main", 8'h00, {7'b0, irq_main});
            if (i == 9) #1 rst = 1'b0;
        end
        report("reset state");

        // Test 2, main CPU writes while the controller is halted
        for (int i = 0; i < 24; i++) cpu_write(9'($urandom), 8'($urandom));
        check_shared();
        report("main CPU shared access");

        // Test 3, immediate loads and stores into shared RAM
        gp = reset_pc;
        for (int i = 0; i < 30; i++) begin
            case ($urandom % 4)
                0, 1: begin
                    emit(op_ldi);
                    emit(8'($urandom));
                    emit3(op_sta, {4'h8, 12'($urandom)});
                end
                2: emit3(op_sta, {4'h8, 12'($urandom)});
                default: begin
                    rd = 8'($urandom);
                    if (rd == op_ldi || rd == op_lda || rd == op_sta || rd == op_jmp)
                        rd = op_nop;
                    emit(rd);
                end
            endcase
        end
        a16 = gp;
        emit3(op_jmp, a16);
        run_prog(a16);
        report("random stores");

        // Test 4, values copied through internal RAM
        gp = reset_pc;
        n_ia = 0;
        for (int i = 0; i < 12; i++) begin
            ia_list[n_ia] = 16'h0040 + 16'($urandom % 256);
            emit(op_ldi);
            emit(8'($urandom));
            emit3(op_sta, ia_list[n_ia]);
            n_ia++;
            emit3(op_lda, ia_list[$urandom % n_ia]);
            emit3(op_sta, {4'h8, 12'($urandom)});
        end
        a16 = gp;
        emit3(op_jmp, a16);
        run_prog(a16);
        report("copy through internal RAM");

        // Test 5, port writes, other offsets are ignored
        gp = reset_pc;
        for (int i = 0; i < 10; i++) begin
            emit(op_ldi);
            emit(8'($urandom));
            emit3(op_sta, (i == 0 || $urandom % 3 != 0) ? 16'h0017 : 16'($urandom % 40));
        end
        a16 = gp;
        emit3(op_jmp, a16);
        run_prog(a16);
        compare_byte("irq_main", {7'b0, m_port6[1]}, {7'b0, irq_main});
        report("port 6 and irq_main");

        // Test 6, NMI routine stores a marker and rearms the latch
        ma = {4'h8, 12'($urandom)};
        gp = nmi_vector;
        emit(op_ldi);
        emit(8'($urandom) | 8'h01);
        emit3(op_sta, ma);
        emit(op_ldi);
        emit(8'h00);
        emit3(op_sta, 16'h0017);
        emit(op_ldi);
        emit(8'h01);
        emit3(op_sta, 16'h0017);
        emit3(op_jmp, reset_pc + 16'h0005);
        gp = reset_pc;
        emit(op_ldi);
        emit(8'h01);
        emit3(op_sta, 16'h0017);
        emit3(op_jmp, reset_pc + 16'h0005);
        run_prog(reset_pc + 16'h0005);
        arm_timeout(64);
        @(posedge clk);
        #1 halt = 1'b0;
        wait_fetch(reset_pc + 16'h0005);
        fire_nmi();
        cpu_write(ma[8:0], 8'h00);
        cpu_read(ma[8:0], rd);
        compare_byte("shared_dout marker cleared", 8'h00, rd);
        arm_timeout(64);
        @(posedge clk);
        #1 halt = 1'b0;
        wait_fetch(reset_pc + 16'h0005);
        fire_nmi();
        report("NMI routine");

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/tb_rom.sv ====
// Program ROM model with a random answer latency and a ready pulse
`timescale 1ns/1ps

module tb_rom (
    input  logic        clk,
    input  logic        rom_cs,
    input  logic [13:0] rom_addr,
    output logic [7:0]  rom_data,
    output logic        rom_ok
);

    logic [7:0] mem [0:16383];
    logic       cs_d;
    int         lat;

    assign rom_data = mem[rom_addr];

    task put(input logic [13:0] a, input logic [7:0] d);
        mem[a] = d;
    endtask

    always @(posedge clk) begin
        cs_d <= rom_cs;
    end

    // One ready pulse per new select, 0 to 6 cycles after it is seen
    initial begin
        rom_ok = 1'b0;
        cs_d   = 1'b0;
        for (int i = 0; i < 16384; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 6);
        end
        forever begin
            @(posedge clk);
            if (rom_cs && !cs_d) begin
                lat = $urandom % 7;
                repeat (lat) @(posedge clk);
                #1 rom_ok = 1'b1;
                @(posedge clk);
                #1 rom_ok = 1'b0;
            end
        end
    end

endmodule

// ==== verilog.f ====
hdl/mcu_pkg.sv
hdl/spram.sv
hdl/rom_wait.sv
hdl/mcu_ports.sv
hdl/mcu_seq.sv
hdl/mcu_sub.sv
sim/tb_rom.sv
sim/tb_mcu_sub.sv
